//--- verilog.f
logic/ppuPkg.sv
logic/vramBusIf.sv
logic/lcdTiming.sv
logic/ppuRegisters.sv
logic/vramArbiter.sv
logic/bgFetcher.sv
logic/ppuTop.sv
tb/vramModel.sv
tb/ppuTb.sv

//--- Bender.yml
package:
  name: ppu_background

sources:
  # Design sources in compile order.
  - files:
      - logic/ppuPkg.sv
      - logic/vramBusIf.sv
      - logic/lcdTiming.sv
      - logic/ppuRegisters.sv
      - logic/vramArbiter.sv
      - logic/bgFetcher.sv
      - logic/ppuTop.sv

  # Testbench sources.
  - target: simulation
    files:
      - tb/vramModel.sv
      - tb/ppuTb.sv

//--- tb/ppuTb.sv
`timescale 1ns/1ns
`default_nettype none

module ppuTb import ppuPkg::*; ();

   logic         clock;
   logic         rst;
   logic [15:0]  cpuAddr;
   logic [7:0]   cpuWriteData;
   logic [7:0]   cpuReadData;
   logic         cpuSelect;
   logic         cpuWrite;
   logic         cpuRead;
   logic [12:0]  vramAddr;
   logic [7:0]   vramWriteData;
   logic [7:0]   vramReadData;
   logic         vramWrite;
   logic         vramRead;
   logic [159:0] lineColorLow;
   logic [159:0] lineColorHigh;
   logic [7:0]   ly;
   logic         irq;
   logic         lineReady;

   int         errors;
   int         checks;
   int         seed;
   bit         timedOut;
   logic [7:0] shadow [0:8191]; // What the CPU has written to video memory.

   ppuTop dut0 (
      .clock(clock), .rst(rst), .cpuAddr(cpuAddr), .cpuWriteData(cpuWriteData),
      .cpuReadData(cpuReadData), .cpuSelect(cpuSelect), .cpuWrite(cpuWrite),
      .cpuRead(cpuRead), .vramAddr(vramAddr), .vramWriteData(vramWriteData),
      .vramReadData(vramReadData), .vramWrite(vramWrite), .vramRead(vramRead),
      .lineColorLow(lineColorLow), .lineColorHigh(lineColorHigh),
      .ly(ly), .irq(irq), .lineReady(lineReady)
   );

   vramModel vram0 (
      .clock(clock), .address(vramAddr), .writeData(vramWriteData),
      .write(vramWrite), .read(vramRead), .readData(vramReadData)
   );

   always #5 clock = ~clock;

   task automatic compareValue(input string name, input logic [159:0] got,
                               input logic [159:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
      end
   endtask

   task automatic noteTimeout(input string what);
      errors++;
      timedOut = 1'b1;
      $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
   endtask

   task automatic writeRegister(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clock);
      cpuSelect    <= 1'b1;
      cpuWrite     <= 1'b1;
      cpuAddr      <= addr;
      cpuWriteData <= data;
      @(posedge clock);
      cpuSelect <= 1'b0;
      cpuWrite  <= 1'b0;
   endtask

   // The LY value seen during the strobe is what STAT compares against.
   task automatic readRegister(input logic [15:0] addr, output logic [7:0] data,
                               output logic [7:0] lySeen);
      @(posedge clock);
      cpuSelect <= 1'b1;
      cpuRead   <= 1'b1;
      cpuAddr   <= addr;
      @(negedge clock);
      lySeen = ly;
      @(posedge clock);
      cpuSelect <= 1'b0;
      cpuRead   <= 1'b0;
      @(negedge clock);
      data = cpuReadData;
   endtask

   // A dropped write must not reach the memory port at all.
   task automatic writeVideoMemory(input logic [12:0] offset, input logic [7:0] data,
                                   input bit dropped);
      @(posedge clock);
      cpuWrite     <= 1'b1;
      cpuAddr      <= {3'b100, offset};
      cpuWriteData <= data;
      @(negedge clock);
      compareValue("vramWrite", vramWrite, !dropped);
      if (!dropped) begin
         compareValue("vramAddr", vramAddr, offset);
         compareValue("vramWriteData", vramWriteData, data);
      end
      @(posedge clock);
      cpuWrite <= 1'b0;
   endtask

   task automatic readVideoMemory(input logic [12:0] offset, output logic [7:0] data,
                                  input bit blocked);
      @(posedge clock);
      cpuRead <= 1'b1;
      cpuAddr <= {3'b100, offset};
      @(negedge clock);
      if (!blocked) begin
         compareValue("vramRead", vramRead, 1'b1);
         compareValue("vramAddr", vramAddr, offset);
      end
      @(posedge clock);
      cpuRead <= 1'b0;
      @(negedge clock);
      data = cpuReadData;
   endtask

   task automatic waitLineReady(output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < 1000 && !ok; n++) begin
         @(negedge clock);
         ok = lineReady;
      end
      if (!ok) noteTimeout("a lineReady pulse");
   endtask

   task automatic waitStatMode(input logic [1:0] wanted, output bit ok);
      int n;
      logic [7:0] stat;
      logic [7:0] lySeen;
      ok = 1'b0;
      for (n = 0; n < 40000 && !ok; n++) begin
         readRegister(addrStat, stat, lySeen);
         ok = (stat[1:0] == wanted);
      end
      if (!ok) noteTimeout("a STAT mode value");
   endtask

   task automatic waitVBlank(output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < 80000 && !ok; n++) begin
         @(negedge clock);
         ok = irq;
      end
      if (!ok) noteTimeout("vertical blank");
   endtask

   // Builds both color planes of one line from the shadow copy of memory.
   task automatic expectedLine(input int line, input bit unsignedTiles,
                               input logic [7:0] palette, output logic [159:0] low,
                               output logic [159:0] high);
      int mapAddr;
      int tileIndex;
      int rowAddr;
      int colorIdx;
      logic [7:0] lo;
      logic [7:0] hi;
      logic [1:0] color;
      for (int t = 0; t < 20; t++) begin
         mapAddr = 'h1800 + 32 * (line / 8) + t;
         if (unsignedTiles) begin
            tileIndex = shadow[mapAddr];
            rowAddr   = 16 * tileIndex + 2 * (line % 8);
         end else begin
            tileIndex = $signed(shadow[mapAddr]);
            rowAddr   = 'h1000 + 16 * tileIndex + 2 * (line % 8);
         end
         lo = shadow[rowAddr];
         hi = shadow[rowAddr + 1];
         for (int i = 0; i < 8; i++) begin
            colorIdx = 2 * hi[7 - i] + lo[7 - i];
            color = palette >> (2 * colorIdx);
            low[8 * t + i]  = color[0];
            high[8 * t + i] = color[1];
         end
      end
   endtask

   task automatic resetValues();
      int startErrors;
      logic [7:0] data;
      logic [7:0] lySeen;
      startErrors = errors;
      @(negedge clock);
      compareValue("irq", irq, 1'b0);
      compareValue("lineReady", lineReady, 1'b0);
      compareValue("vramWrite", vramWrite, 1'b0);
      compareValue("vramRead", vramRead, 1'b0);
      compareValue("ly", ly, 8'd0);
      compareValue("lineColorLow", lineColorLow, 160'd0);
      compareValue("lineColorHigh", lineColorHigh, 160'd0);
      readRegister(addrLcdc, data, lySeen);
      compareValue("LCDC", data, 8'h00);
      readRegister(addrLyc, data, lySeen);
      compareValue("LYC", data, 8'h00);
      readRegister(addrBgp, data, lySeen);
      compareValue("BGP", data, 8'h00);
      readRegister(addrStat, data, lySeen);
      compareValue("STAT", data, 8'h84); // LY and LYC are both zero.
      $display("Reset value test finished with %0d errors", errors - startErrors);
   endtask

   task automatic registerAccess();
      int startErrors;
      logic [7:0] data;
      logic [7:0] lySeen;
      startErrors = errors;
      writeRegister(addrLcdc, 8'h53); // Bit 7 clear keeps the display off.
      writeRegister(addrLyc, 8'h2A);
      writeRegister(addrBgp, 8'hE4);
      writeRegister(addrStat, 8'h5F);
      writeRegister(addrLy, 8'h33);
      readRegister(addrLcdc, data, lySeen);
      compareValue("LCDC", data, 8'h53);
      readRegister(addrLyc, data, lySeen);
      compareValue("LYC", data, 8'h2A);
      readRegister(addrBgp, data, lySeen);
      compareValue("BGP", data, 8'hE4);
      readRegister(addrStat, data, lySeen);
      compareValue("STAT", data,
                   8'h80 | (8'h5F & 8'h78) | ((lySeen == 8'h2A) ? 8'h04 : 8'h00));
      readRegister(addrLy, data, lySeen);
      compareValue("LY", data, 8'h00);
      readRegister(16'hFF42, data, lySeen);
      compareValue("unmapped register", data, 8'hFF);
      $display("Register access test finished with %0d errors", errors - startErrors);
   endtask

   task automatic frameTiming();
      int startErrors;
      int cyc;
      int lastPulse;
      int pulses;
      logic [7:0] prevLy;
      bit wrapSeen;
      startErrors = errors;
      lastPulse = -1;
      pulses = 0;
      wrapSeen = 1'b0;
      writeRegister(addrLcdc, 8'h91);
      @(negedge clock);
      prevLy = ly;
      for (cyc = 0; cyc < 156 * 456; cyc++) begin
         @(negedge clock);
         if (lineReady) begin
            if (lastPulse >= 0 && ly != 8'd0) begin
               compareValue("lineReady spacing", cyc - lastPulse, 456);
            end
            lastPulse = cyc;
            pulses++;
         end
         if (ly != prevLy) begin
            compareValue("ly", ly, (prevLy == 8'd153) ? 8'd0 : prevLy + 8'd1);
            if (prevLy == 8'd153) wrapSeen = 1'b1;
            prevLy = ly;
         end
         compareValue("irq", irq, ly >= 8'd144); // High exactly through vertical blank.
      end
      checks += 2;
      if (!wrapSeen) begin
         errors++;
         $display("LY never wrapped from 153 back to 0");
      end
      if (pulses < 144) begin
         errors++;
         $display("Only %0d lineReady pulses were seen in a whole frame", pulses);
      end
      $display("Frame timing test finished with %0d errors", errors - startErrors);
   endtask

   task automatic coincidenceFlag();
      int startErrors;
      int n;
      int hits;
      bit done;
      logic [7:0] stat;
      logic [7:0] lySeen;
      startErrors = errors;
      hits = 0;
      done = 1'b0;
      writeRegister(addrLyc, 8'd3);
      for (n = 0; n < 40000 && !done; n++) begin
         readRegister(addrStat, stat, lySeen);
         compareValue("STAT coincidence bit", stat[2], lySeen == 8'd3);
         if (stat[2]) begin
            hits++;
         end else if (hits > 0) begin
            done = 1'b1;
         end
      end
      if (!done) begin
         noteTimeout("LY to pass over LYC");
         return;
      end
      $display("Coincidence test finished with %0d errors", errors - startErrors);
   endtask

   // The display restarts at line 0, so the k-th pulse belongs to line k.
   task automatic renderLines(input logic [7:0] control, input logic [7:0] palette);
      bit ok;
      logic [159:0] low;
      logic [159:0] high;
      writeRegister(addrLcdc, 8'h00);
      writeRegister(addrLcdc, control);
      for (int k = 0; k < 10; k++) begin
         waitLineReady(ok);
         if (!ok) return;
         expectedLine(k, control[4], palette, low, high);
         compareValue("lineColorLow", lineColorLow, low);
         compareValue("lineColorHigh", lineColorHigh, high);
      end
   endtask

   task automatic backgroundRendering();
      int startErrors;
      logic [7:0] value;
      startErrors = errors;
      writeRegister(addrLcdc, 8'h00);
      for (int a = 0; a < 8192; a++) begin
         value = $random(seed);
         shadow[a] = value;
         writeVideoMemory(a[12:0], value, 1'b0);
      end
      writeRegister(addrBgp, 8'h2D); // Four distinct shades in a shuffled order.
      renderLines(8'h91, 8'h2D);
      if (timedOut) return;
      renderLines(8'h81, 8'h2D);
      if (timedOut) return;
      $display("Background rendering test finished with %0d errors", errors - startErrors);
   endtask

   task automatic accessBlocking();
      int startErrors;
      bit ok;
      logic [7:0] data;
      logic [7:0] newValue;
      startErrors = errors;
      newValue = ~shadow['h123];
      writeRegister(addrLcdc, 8'h91);
      waitStatMode(2'd2, ok); // Start of a line, so transfer is caught early.
      if (!ok) return;
      waitStatMode(2'd3, ok);
      if (!ok) return;
      readVideoMemory(13'h0123, data, 1'b1);
      compareValue("blocked read data", data, 8'hFF);
      writeVideoMemory(13'h0123, newValue, 1'b1);
      waitVBlank(ok);
      if (!ok) return;
      readVideoMemory(13'h0123, data, 1'b0);
      compareValue("byte after blocked write", data, shadow['h123]);
      writeVideoMemory(13'h0123, newValue, 1'b0);
      shadow['h123] = newValue;
      readVideoMemory(13'h0123, data, 1'b0);
      compareValue("byte after vBlank write", data, newValue);
      $display("Access blocking test finished with %0d errors", errors - startErrors);
   endtask

   initial begin
      errors       = 0;
      checks       = 0;
      seed         = 2873;
      timedOut     = 1'b0;
      clock        = 1'b0;
      rst          = 1'b1;
      cpuAddr      = '0;
      cpuWriteData = '0;
      cpuSelect    = 1'b0;
      cpuWrite     = 1'b0;
      cpuRead      = 1'b0;
      repeat (8) @(posedge clock);
      rst <= 1'b0;
      @(posedge clock);
      resetValues();
      registerAccess();
      if (!timedOut) frameTiming();
      if (!timedOut) coincidenceFlag();
      if (!timedOut) backgroundRendering();
      if (!timedOut) accessBlocking();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/vramModel.sv
`timescale 1ns/1ns
`default_nettype none

// Video memory model with read data one clock after the request.
module vramModel (
   input  logic        clock,
   input  logic [12:0] address,
   input  logic [7:0]  writeData,
   input  logic        write,
   input  logic        read,
   output logic [7:0]  readData
);

   logic [7:0] mem [0:8191];

   initial begin
      for (int i = 0; i < 8192; i++) begin
         mem[i] = i[7:0] ^ {i[12:8], 3'b101}; // Fill built from the whole address.
      end
      readData = '0;
   end

   always @(posedge clock) begin
      if (write) begin
         mem[address] <= writeData;
      end
      if (read) begin
         readData <= mem[address];
      end
   end

endmodule

`default_nettype wire

//--- logic/ppuTop.sv
`timescale 1ns/1ns
`default_nettype none

module ppuTop import ppuPkg::*; #(
   parameter int dotsPerLine    = 456,
   parameter int visibleLines   = 144,
   parameter int totalLines     = 154,
   parameter int oamScanDots    = 80,
   parameter int transferEndDot = 252
) (
   input  logic                     clock,
   input  logic                     rst,
   input  logic [15:0]              cpuAddr,
   input  byte_t                    cpuWriteData,
   output byte_t                    cpuReadData,
   input  logic                     cpuSelect,
   input  logic                     cpuWrite,
   input  logic                     cpuRead,
   output vramAddr_t                vramAddr,
   output byte_t                    vramWriteData,
   input  byte_t                    vramReadData,
   output logic                     vramWrite,
   output logic                     vramRead,
   output logic [pixelsPerLine-1:0] lineColorLow,
   output logic [pixelsPerLine-1:0] lineColorHigh,
   output byte_t                    ly,
   output logic                     irq,
   output logic                     lineReady
);

   lcdc_t    lcdc;
   byte_t    lyc;
   byte_t    bgp;
   byte_t    regReadData;
   logic     regReadValid;
   logic     coincidence;
   ppuMode_t mode;

   vramBusIf fetchBus ();

   lcdTiming #(
      .dotsPerLine   (dotsPerLine),
      .visibleLines  (visibleLines),
      .totalLines    (totalLines),
      .oamScanDots   (oamScanDots),
      .transferEndDot(transferEndDot)
   ) timing0 (
      .clock      (clock),
      .rst        (rst),
      .lcdEnable  (lcdc.bits.lcdEnable),
      .lyc        (lyc),
      .ly         (ly),
      .mode       (mode),
      .coincidence(coincidence)
   );

   ppuRegisters registers0 (
      .clock(clock), .rst(rst), .cpuAddr(cpuAddr), .cpuWriteData(cpuWriteData),
      .cpuSelect(cpuSelect), .cpuWrite(cpuWrite), .cpuRead(cpuRead),
      .ly(ly), .mode(mode), .coincidence(coincidence),
      .lcdc(lcdc), .lyc(lyc), .bgp(bgp),
      .regReadData(regReadData), .regReadValid(regReadValid)
   );

   vramArbiter arbiter0 (
      .clock(clock), .rst(rst), .mode(mode), .cpuAddr(cpuAddr),
      .cpuWriteData(cpuWriteData), .cpuSelect(cpuSelect), .cpuWrite(cpuWrite),
      .cpuRead(cpuRead), .regReadData(regReadData), .regReadValid(regReadValid),
      .fetch(fetchBus.arbiter), .vramAddr(vramAddr), .vramWriteData(vramWriteData),
      .vramWrite(vramWrite), .vramRead(vramRead), .vramReadData(vramReadData),
      .cpuReadData(cpuReadData)
   );

   bgFetcher #(.visibleLines(visibleLines)) fetcher0 (
      .clock(clock), .rst(rst), .mode(mode), .ly(ly), .lcdc(lcdc), .bgp(bgp),
      .bus(fetchBus.requester), .lineColorLow(lineColorLow),
      .lineColorHigh(lineColorHigh), .lineReady(lineReady)
   );

   assign irq = (mode == vBlank); // Level held for the whole vertical blank.

endmodule

`default_nettype wire

//--- logic/bgFetcher.sv
`timescale 1ns/1ns
`default_nettype none

module bgFetcher import ppuPkg::*; #(
   parameter int visibleLines = 144
) (
   input  logic                     clock,
   input  logic                     rst,
   input  ppuMode_t                 mode,
   input  byte_t                    ly,
   input  lcdc_t                    lcdc,
   input  byte_t                    bgp,
   vramBusIf.requester              bus,
   output logic [pixelsPerLine-1:0] lineColorLow,
   output logic [pixelsPerLine-1:0] lineColorHigh,
   output logic                     lineReady
);

   logic [2:0] phase;      // Six steps per tile.
   logic [4:0] tileIdx;
   logic       lineDone;
   logic       fetching;
   byte_t      tileNum;
   byte_t      lowByte;
   vramAddr_t  mapAddr;
   vramAddr_t  rowAddr;
   logic [7:0] pieceLow;
   logic [7:0] pieceHigh;
   ppuMode_t   prevMode;
   logic       firstHBlank;

   assign fetching = (mode == transfer) && !lineDone;

   assign mapAddr = tileMapBase + vramAddr_t'(ly[7:3]) * vramAddr_t'(mapRowTiles)
                  + vramAddr_t'(tileIdx);

   // Unsigned tiles start at 0000h, signed ones are centered on 1000h.
   always_comb begin
      if (lcdc.bits.tileDataSelect) begin
         rowAddr = {1'b0, tileNum, ly[2:0], 1'b0};
      end else begin
         rowAddr = signedTileBase + {tileNum[7], tileNum, ly[2:0], 1'b0};
      end
   end

   always_comb begin
      case (phase[2:1])
         2'd0:    bus.address = mapAddr;
         2'd1:    bus.address = rowAddr;
         default: bus.address = rowAddr + 13'd1;
      endcase
   end

   assign bus.read      = fetching && !phase[0];
   assign bus.write     = 1'b0;
   assign bus.writeData = '0;

   // The high byte is on the bus while the tile is stored.
   always_comb begin
      for (int j = 0; j < 8; j++) begin
         pieceLow[j]  = bgp[{bus.readData[7-j], lowByte[7-j], 1'b0}];
         pieceHigh[j] = bgp[{bus.readData[7-j], lowByte[7-j], 1'b1}];
      end
   end

   always_ff @(posedge clock) begin
      if (rst) begin
         phase         <= '0;
         tileIdx       <= '0;
         lineDone      <= 1'b0;
         lineColorLow  <= '0;
         lineColorHigh <= '0;
      end else if (mode != transfer) begin
         phase    <= '0;
         tileIdx  <= '0;
         lineDone <= 1'b0;
      end else if (!lineDone) begin
         phase <= (phase == 3'd5) ? 3'd0 : phase + 3'd1;
         if (phase == 3'd5) begin
            lineColorLow[{tileIdx, 3'b000} +: 8]  <= pieceLow;
            lineColorHigh[{tileIdx, 3'b000} +: 8] <= pieceHigh;
            if (tileIdx == 5'(tilesPerLine - 1)) begin
               lineDone <= 1'b1;
            end else begin
               tileIdx <= tileIdx + 5'd1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (fetching && phase == 3'd1) begin
         tileNum <= bus.readData;
      end
      if (fetching && phase == 3'd3) begin
         lowByte <= bus.readData;
      end
   end

   assign firstHBlank = lcdc.bits.lcdEnable && (ly < 8'(visibleLines))
                      && (mode == hBlank) && (prevMode == transfer);

   always_ff @(posedge clock) begin
      if (rst) begin
         prevMode  <= hBlank;
         lineReady <= 1'b0;
      end else begin
         prevMode  <= mode;
         lineReady <= firstHBlank; // Lands on the second hBlank cycle.
      end
   end

   // All tiles of the line are stored before transfer gives way to hBlank.
   lineFetchedInTime: assert property (
      @(posedge clock) disable iff (rst)
      firstHBlank |-> lineDone
   );

endmodule

`default_nettype wire

//--- logic/vramArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module vramArbiter import ppuPkg::*; (
   input  logic        clock,
   input  logic        rst,
   input  ppuMode_t    mode,
   input  logic [15:0] cpuAddr,
   input  byte_t       cpuWriteData,
   input  logic        cpuSelect,
   input  logic        cpuWrite,
   input  logic        cpuRead,
   input  byte_t       regReadData,
   input  logic        regReadValid,
   vramBusIf.arbiter   fetch,
   output vramAddr_t   vramAddr,
   output byte_t       vramWriteData,
   output logic        vramWrite,
   output logic        vramRead,
   input  byte_t       vramReadData,
   output byte_t       cpuReadData
);

   logic fetcherOwns;
   logic cpuVram;
   logic blockedRead;

   assign fetcherOwns = (mode == transfer);

   // Video memory sits at 8000h to 9FFFh on the CPU side.
   assign cpuVram = !cpuSelect && (cpuAddr[15:13] == 3'b100);

   assign vramAddr      = fetcherOwns ? fetch.address   : cpuAddr[12:0];
   assign vramWriteData = fetcherOwns ? fetch.writeData : cpuWriteData;
   assign vramWrite     = fetcherOwns ? fetch.write     : (cpuVram && cpuWrite);
   assign vramRead      = fetcherOwns ? fetch.read      : (cpuVram && cpuRead);

   assign fetch.readData = vramReadData;

   always_ff @(posedge clock) begin
      if (rst) begin
         blockedRead <= 1'b0;
      end else begin
         blockedRead <= cpuVram && cpuRead && fetcherOwns;
      end
   end

   always_comb begin
      if (regReadValid) begin
         cpuReadData = regReadData;
      end else if (blockedRead) begin
         cpuReadData = blockedByte;
      end else begin
         cpuReadData = vramReadData;
      end
   end

   // The fetcher only reads, and CPU writes are dropped during transfer.
   noWriteInTransfer: assert property (
      @(posedge clock) disable iff (rst)
      fetcherOwns |-> !vramWrite
   );

endmodule

`default_nettype wire

//--- logic/ppuRegisters.sv
`timescale 1ns/1ns
`default_nettype none

module ppuRegisters import ppuPkg::*; (
   input  logic        clock,
   input  logic        rst,
   input  logic [15:0] cpuAddr,
   input  byte_t       cpuWriteData,
   input  logic        cpuSelect,
   input  logic        cpuWrite,
   input  logic        cpuRead,
   input  byte_t       ly,
   input  ppuMode_t    mode,
   input  logic        coincidence,
   output lcdc_t       lcdc,
   output byte_t       lyc,
   output byte_t       bgp,
   output byte_t       regReadData,
   output logic        regReadValid
);

   logic [3:0] statBits; // STAT bits 6 to 3.
   byte_t      readMux;

   always_ff @(posedge clock) begin
      if (rst) begin
         lcdc.raw <= '0;
         statBits <= '0;
         lyc      <= '0;
         bgp      <= '0;
      end else if (cpuSelect && cpuWrite) begin
         case (cpuAddr)
            addrLcdc: lcdc.raw <= cpuWriteData;
            addrStat: statBits <= cpuWriteData[6:3];
            addrLyc:  lyc      <= cpuWriteData;
            addrBgp:  bgp      <= cpuWriteData;
            default: ;  // LY and unmapped addresses are read only.
         endcase
      end
   end

   always_comb begin
      case (cpuAddr)
         addrLcdc: readMux = lcdc.raw;
         addrStat: readMux = {1'b1, statBits, coincidence, mode};
         addrLy:   readMux = ly;
         addrLyc:  readMux = lyc;
         addrBgp:  readMux = bgp;
         default:  readMux = 8'hFF;
      endcase
   end

   always_ff @(posedge clock) begin
      if (rst) begin
         regReadValid <= 1'b0;
      end else begin
         regReadValid <= cpuSelect && cpuRead;
      end
   end

   // Captured on every cycle, only looked at while regReadValid is high.
   always_ff @(posedge clock) begin
      regReadData <= readMux;
   end

endmodule

`default_nettype wire

//--- logic/lcdTiming.sv
`timescale 1ns/1ns
`default_nettype none

module lcdTiming import ppuPkg::*; #(
   parameter int dotsPerLine    = 456,
   parameter int visibleLines   = 144,
   parameter int totalLines     = 154,
   parameter int oamScanDots    = 80,
   parameter int transferEndDot = 252
) (
   input  logic     clock,
   input  logic     rst,
   input  logic     lcdEnable,
   input  byte_t    lyc,
   output byte_t    ly,
   output ppuMode_t mode,
   output logic     coincidence
);

   localparam int dotBits = $clog2(dotsPerLine);

   logic [dotBits-1:0] dot;
   logic               lineEnd;

   assign lineEnd = (dot == dotBits'(dotsPerLine - 1));

   // A disabled display holds both counters at the top-left position.
   always_ff @(posedge clock) begin
      if (rst || !lcdEnable) begin
         dot <= '0;
         ly  <= '0;
      end else begin
         if (lineEnd) begin
            dot <= '0;
            if (ly == 8'(totalLines - 1)) begin
               ly <= '0;
            end else begin
               ly <= ly + 8'd1;
            end
         end else begin
            dot <= dot + 1'b1;
         end
      end
   end

   always_comb begin
      if (!lcdEnable) begin
         mode = hBlank;
      end else if (ly >= 8'(visibleLines)) begin
         mode = vBlank;
      end else if (dot < dotBits'(oamScanDots)) begin
         mode = oamScan;
      end else if (dot < dotBits'(transferEndDot)) begin
         mode = transfer;
      end else begin
         mode = hBlank;
      end
   end

   assign coincidence = (ly == lyc);

   // Pixel transfer is only ever entered from the OAM scan of its line.
   transferAfterOamScan: assert property (
      @(posedge clock) disable iff (rst)
      (mode == transfer) |-> ($past(mode) == oamScan || $past(mode) == transfer)
   );

endmodule

`default_nettype wire

//--- logic/vramBusIf.sv
`timescale 1ns/1ns
`default_nettype none

// Video-memory request path from the background fetcher to the arbiter.
interface vramBusIf import ppuPkg::*; ();

   vramAddr_t address;
   byte_t     writeData;
   byte_t     readData;   // Valid one clock after a read request.
   logic      write;
   logic      read;

   modport requester (
      output address,
      output writeData,
      output write,
      output read,
      input  readData
   );

   modport arbiter (
      input  address,
      input  writeData,
      input  write,
      input  read,
      output readData
   );

endinterface

`default_nettype wire

//--- logic/ppuPkg.sv
`default_nettype none

package ppuPkg;

   typedef logic [12:0] vramAddr_t;
   typedef logic [7:0] byte_t;

   typedef enum logic [1:0] {
      hBlank   = 2'd0,
      vBlank   = 2'd1,
      oamScan  = 2'd2,
      transfer = 2'd3
   } ppuMode_t;

   // LCDC is written by the CPU as a byte and read by the renderer as bits.
   typedef union packed {
      byte_t raw;
      struct packed {
         logic lcdEnable;
         logic windowMap;
         logic windowEnable;
         logic tileDataSelect;
         logic bgMapSelect;
         logic objSize;
         logic objEnable;
         logic bgEnable;
      } bits;
   } lcdc_t;

   localparam logic [15:0] addrLcdc = 16'hFF40;
   localparam logic [15:0] addrStat = 16'hFF41;
   localparam logic [15:0] addrLy   = 16'hFF44;
   localparam logic [15:0] addrLyc  = 16'hFF45;
   localparam logic [15:0] addrBgp  = 16'hFF47;

   localparam vramAddr_t tileMapBase    = 13'h1800;
   localparam vramAddr_t signedTileBase = 13'h1000;

   localparam int tilesPerLine  = 20;
   localparam int pixelsPerLine = 160;
   localparam int mapRowTiles   = 32; // Map entries per row of tiles.

   localparam byte_t blockedByte = 8'hFF;

endpackage

`default_nettype wire
